// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_compy
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, the simulator status is lost in the pipe.
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/compy_pkg.sv
`include "compy_settings.svh"

package compy_pkg;

   // named view of the key word, key_reset sits in the top bit.
   typedef struct packed {
      logic                           key_reset;
      logic                           key_mode;
      logic [`COMPY_BUTTON_COUNT-1:0] buttons;
   } key_fields_t;

   // the same seven bits, read either per key name or by index.
   typedef union packed {
      key_fields_t                 fields;
      logic [`COMPY_KEY_COUNT-1:0] bits;
   } key_word_u;

endpackage

// File: common/compy_settings.svh
`ifndef COMPY_SETTINGS_SVH
`define COMPY_SETTINGS_SVH

// number of keys on the board: reset, mode and the plain buttons.
`define COMPY_KEY_COUNT 7

`define COMPY_BUTTON_COUNT 5

// clock cycles between two debounce samples.
// small for simulation. A real board wants a millisecond or so.
`define COMPY_TICK_DIV 4

// consecutive differing samples before a debounced level may flip.
`define COMPY_STABLE_TICKS 4

// cycles of PLL lock the system core stays in reset after power up.
`define COMPY_BOOT_HOLD 32

`endif

// File: common/key_event_if.sv
`timescale 1ns/1ps

interface key_event_if import compy_pkg::*; ();

   key_word_u pressed;     // 1 while the key is held down.
   key_word_u press;       // one-cycle pulse per key going down.
   key_word_u release_ev;  // one-cycle pulse per key coming back up.
   logic      any_change;

   modport source (
      output pressed,
      output press,
      output release_ev,
      output any_change
   );

   modport sink (
      input pressed,
      input press,
      input release_ev,
      input any_change
   );

endinterface

// File: debounce/debouncer.sv
`timescale 1ns/1ps
`include "compy_settings.svh"

module debouncer (
   input  logic clk50,
   input  logic rst_n,
   input  logic sample_tick,
   input  logic raw,
   output logic stable
);

   localparam int CNT_W = (`COMPY_STABLE_TICKS > 1) ? $clog2(`COMPY_STABLE_TICKS) : 1;

   logic [CNT_W-1:0] diff_cnt;   // consecutive ticks where raw disagreed with stable.

   // the input is only looked at on sample ticks. Between ticks nothing moves,
   // so short bounces between two samples are never seen at all.
   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         stable   <= 1'b1;
         diff_cnt <= '0;
      end else if (sample_tick) begin
         if (raw == stable) begin
            diff_cnt <= '0;   // a single agreeing sample starts over.
         end else if (diff_cnt == CNT_W'(`COMPY_STABLE_TICKS - 1)) begin
            stable   <= raw;
            diff_cnt <= '0;
         end else begin
            diff_cnt <= diff_cnt + 1'b1;
         end
      end
   end

endmodule

// File: rtl/compy.sv
`timescale 1ns/1ps
`include "compy_settings.svh"

module compy import compy_pkg::*; (
   input  logic                           clk50,
   input  logic                           rst_n,
   input  logic                           pll_locked,
   input  logic                           key_reset,
   input  logic                           key_mode,
   input  logic [`COMPY_BUTTON_COUNT-1:0] buttons,
   output logic                           sys_rst_n,
   output logic                           key_mode_level,
   output logic [`COMPY_BUTTON_COUNT-1:0] buttons_level,
   output logic [`COMPY_KEY_COUNT-1:0]    press_events,
   output logic [`COMPY_KEY_COUNT-1:0]    release_events,
   output logic                           key_activity
);

   key_word_u sync_w;     // synchronized raw keys, active low.
   key_word_u stable_w;   // debounced keys, still active low.
   logic      sample_tick;

   key_event_if ev ();

   input_sync i_sync (
      .clk50      (clk50),
      .rst_n      (rst_n),
      .key_reset  (key_reset),
      .key_mode   (key_mode),
      .buttons    (buttons),
      .sync       (sync_w),
      .sample_tick(sample_tick)
   );

   for (genvar i = 0; i < `COMPY_KEY_COUNT; i++) begin : g_deb
      debouncer i_deb (
         .clk50      (clk50),
         .rst_n      (rst_n),
         .sample_tick(sample_tick),
         .raw        (sync_w.bits[i]),
         .stable     (stable_w.bits[i])
      );
   end

   key_event_collector i_collect (
      .clk50 (clk50),
      .rst_n (rst_n),
      .stable(stable_w),
      .ev    (ev.source)
   );

   reset_sequencer i_rst_seq (
      .clk50     (clk50),
      .rst_n     (rst_n),
      .pll_locked(pll_locked),
      .ev        (ev.sink),
      .sys_rst_n (sys_rst_n)
   );

   // the core sees held levels per key name and raw event words by index.
   assign key_mode_level = ev.pressed.fields.key_mode;
   assign buttons_level  = ev.pressed.fields.buttons;
   assign press_events   = ev.press.bits;
   assign release_events = ev.release_ev.bits;
   assign key_activity   = ev.any_change;

endmodule

// File: rtl/input_sync.sv
`timescale 1ns/1ps
`include "compy_settings.svh"

module input_sync import compy_pkg::*; (
   input  logic                           clk50,
   input  logic                           rst_n,
   input  logic                           key_reset,
   input  logic                           key_mode,
   input  logic [`COMPY_BUTTON_COUNT-1:0] buttons,
   output key_word_u                      sync,
   output logic                           sample_tick
);

   localparam int TICK_W = (`COMPY_TICK_DIV > 1) ? $clog2(`COMPY_TICK_DIV) : 1;

   key_word_u         raw_w;
   key_word_u         sync_q1;
   logic [TICK_W-1:0] tick_cnt;

   always_comb begin
      raw_w.fields.key_reset = key_reset;
      raw_w.fields.key_mode  = key_mode;
      raw_w.fields.buttons   = buttons;
   end

   // keys are active low, so the flops come out of reset as released.
   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         sync_q1.bits <= '1;
         sync.bits    <= '1;
      end else begin
         sync_q1 <= raw_w;
         sync    <= sync_q1;
      end
   end

   // one prescaler serves all seven debouncers.
   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         tick_cnt    <= TICK_W'(`COMPY_TICK_DIV - 1);
         sample_tick <= 1'b0;
      end else if (tick_cnt == '0) begin
         tick_cnt    <= TICK_W'(`COMPY_TICK_DIV - 1);
         sample_tick <= 1'b1;
      end else begin
         tick_cnt    <= tick_cnt - 1'b1;
         sample_tick <= 1'b0;
      end
   end

endmodule

// File: rtl/key_event_collector.sv
`timescale 1ns/1ps

module key_event_collector import compy_pkg::*; (
   input  logic             clk50,
   input  logic             rst_n,
   input  key_word_u        stable,
   key_event_if.source      ev
);

   key_word_u next_pressed;

   assign next_pressed.bits = ~stable.bits;   // debounced keys are still active low.

   // the registered pressed word doubles as the previous value for edge detection,
   // so the pulses line up with the cycle in which pressed changes.
   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         ev.pressed.bits    <= '0;
         ev.press.bits      <= '0;
         ev.release_ev.bits <= '0;
         ev.any_change      <= 1'b0;
      end else begin
         ev.pressed         <= next_pressed;
         ev.press.bits      <= next_pressed.bits & ~ev.pressed.bits;
         ev.release_ev.bits <= ~next_pressed.bits & ev.pressed.bits;
         ev.any_change      <= |(next_pressed.bits ^ ev.pressed.bits);
      end
   end

endmodule

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ps
`include "compy_settings.svh"

module reset_sequencer (
   input  logic        clk50,
   input  logic        rst_n,
   input  logic        pll_locked,
   key_event_if.sink   ev,
   output logic        sys_rst_n
);

   localparam int BOOT_W = (`COMPY_BOOT_HOLD > 1) ? $clog2(`COMPY_BOOT_HOLD) : 1;

   logic [BOOT_W-1:0] boot_cnt;
   logic              boot_done;
   logic              user_req;

   // counts locked cycles only. A dropped lock just pauses the count.
   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         boot_cnt  <= '0;
         boot_done <= 1'b0;
      end else if (pll_locked && !boot_done) begin
         if (boot_cnt == BOOT_W'(`COMPY_BOOT_HOLD - 1)) begin
            boot_done <= 1'b1;
         end else begin
            boot_cnt <= boot_cnt + 1'b1;
         end
      end
   end

   // the reset key only counts once the board has booted with a good clock.
   assign user_req = boot_done & pll_locked & ev.pressed.fields.key_reset;

   always_ff @(posedge clk50) begin
      if (!rst_n) begin
         sys_rst_n <= 1'b0;
      end else begin
         sys_rst_n <= boot_done & ~user_req;
      end
   end

endmodule

// File: tb.f
+incdir+common
common/compy_pkg.sv
common/key_event_if.sv
rtl/input_sync.sv
debounce/debouncer.sv
rtl/key_event_collector.sv
rtl/reset_sequencer.sv
rtl/compy.sv
verif/clock_gen.sv
verif/tb_compy.sv

// File: verif/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
   parameter real PERIOD_NS = 10.0
) (
   output logic clk
);

   // free running from time zero, first rising edge at half a period.
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

// File: verif/tb_compy.sv
`timescale 1ns/1ps
`include "compy_settings.svh"

module tb_compy import compy_pkg::*; ();

   localparam int EVENT_TIMEOUT  = 100;
   localparam int SETTLE_TIMEOUT = 200;
   localparam int GLITCH_MAX     = (`COMPY_STABLE_TICKS - 1) * `COMPY_TICK_DIV;

   logic                           clk50;
   logic                           rst_n;
   logic                           pll_locked;
   key_word_u                      keys;   // active-low raw key levels.
   logic                           sys_rst_n;
   logic                           key_mode_level;
   logic [`COMPY_BUTTON_COUNT-1:0] buttons_level;
   logic [`COMPY_KEY_COUNT-1:0]    press_events;
   logic [`COMPY_KEY_COUNT-1:0]    release_events;
   logic                           key_activity;

   key_word_u m_sync1;
   key_word_u m_sync2;
   key_word_u m_stable;    // debounced keys that are still active low.
   key_word_u m_pressed;
   key_word_u m_press;
   key_word_u m_release;
   int        m_phase;
   logic      m_tick;
   int        m_run [`COMPY_KEY_COUNT];
   int        m_locked;
   logic      m_sys;

   clock_gen #(.PERIOD_NS(10.0)) i_clk (.clk(clk50));

   compy i_compy (
      .clk50         (clk50),
      .rst_n         (rst_n),
      .pll_locked    (pll_locked),
      .key_reset     (keys.fields.key_reset),
      .key_mode      (keys.fields.key_mode),
      .buttons       (keys.fields.buttons),
      .sys_rst_n     (sys_rst_n),
      .key_mode_level(key_mode_level),
      .buttons_level (buttons_level),
      .press_events  (press_events),
      .release_events(release_events),
      .key_activity  (key_activity)
   );

   task automatic flag_mismatch(input string what);
      $display("Mismatch at %0d ns: %s", $time, what);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1);
   endtask

   // the reference model keeps one sample tick every TICK_DIV cycles and a run count per key.
   always @(posedge clk50) begin
      if (!rst_n) begin
         m_sync1.bits   <= '1;
         m_sync2.bits   <= '1;
         m_stable.bits  <= '1;
         m_pressed.bits <= '0;
         m_press.bits   <= '0;
         m_release.bits <= '0;
         m_phase        <= 0;
         m_tick         <= 1'b0;
         m_locked       <= 0;
         m_sys          <= 1'b0;
         for (int k = 0; k < `COMPY_KEY_COUNT; k++) begin
            m_run[k] = 0;
         end
      end else begin
         m_sync1 <= keys;
         m_sync2 <= m_sync1;
         m_phase <= (m_phase + 1) % `COMPY_TICK_DIV;
         m_tick  <= (m_phase == `COMPY_TICK_DIV - 1);
         for (int k = 0; k < `COMPY_KEY_COUNT; k++) begin
            if (m_tick && m_sync2.bits[k] != m_stable.bits[k]) begin
               if (m_run[k] + 1 == `COMPY_STABLE_TICKS) begin
                  m_stable.bits[k] <= m_sync2.bits[k];
                  m_run[k]         = 0;
               end else begin
                  m_run[k] = m_run[k] + 1;
               end
            end else if (m_tick) begin
               m_run[k] = 0;   // an agreeing sample starts the run over.
            end
         end
         m_pressed.bits <= ~m_stable.bits;
         m_press.bits   <= ~m_stable.bits & ~m_pressed.bits;
         m_release.bits <= m_stable.bits & m_pressed.bits;
         if (pll_locked && m_locked < `COMPY_BOOT_HOLD) begin
            m_locked <= m_locked + 1;
         end
         m_sys <= (m_locked == `COMPY_BOOT_HOLD) && !(pll_locked && m_pressed.fields.key_reset);
      end
   end

   a_sys_rst: assert property (@(posedge clk50) disable iff (!rst_n) sys_rst_n == m_sys)
      else flag_mismatch("sys_rst_n differs from the model");
   a_press: assert property (@(posedge clk50) disable iff (!rst_n) press_events == m_press.bits)
      else flag_mismatch("press_events differ from the model");
   a_release: assert property (@(posedge clk50) disable iff (!rst_n)
      release_events == m_release.bits)
      else flag_mismatch("release_events differ from the model");
   a_activity: assert property (@(posedge clk50) disable iff (!rst_n)
      key_activity == ((|m_press.bits) || (|m_release.bits)))
      else flag_mismatch("key_activity differs from the model");
   a_levels: assert property (@(posedge clk50) disable iff (!rst_n)
      key_mode_level == m_pressed.fields.key_mode && buttons_level == m_pressed.fields.buttons)
      else flag_mismatch("key levels differ from the model");

   // drives one key and waits for its single event pulse.
   task automatic move_key(input int k, input bit down);
      int                          n;
      logic [`COMPY_KEY_COUNT-1:0] seen;
      n = 0;
      keys.bits[k] = !down;
      seen = down ? press_events : release_events;
      while (seen[k] !== 1'b1) begin
         if (n == EVENT_TIMEOUT) begin
            abort_run($sformatf("key %0d gave no event within %0d cycles", k, n));
         end else begin
            @(negedge clk50);
            n++;
            seen = down ? press_events : release_events;
         end
      end
      assert (seen == `COMPY_KEY_COUNT'(1 << k) && key_activity)
         else flag_mismatch($sformatf("event word %b for key %0d", seen, k));
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk50);
         assert (press_events == '0 && release_events == '0)
            else flag_mismatch("a short glitch produced a key event");
      end
   endtask

   initial begin
      int drop;
      int n;
      int k;
      int hold_left [`COMPY_KEY_COUNT];
      void'($urandom(32'h579a1d32));
      rst_n      = 1'b0;
      pll_locked = 1'b0;
      keys.bits  = '1;
      repeat (8) @(negedge clk50);
      rst_n = 1'b1;

      // boot hold with one lock drop part way through the count.
      repeat ($urandom_range(5, 20)) @(negedge clk50);
      assert (sys_rst_n == 1'b0) else flag_mismatch("system reset released before PLL lock");
      drop       = $urandom_range(1, 8);
      n          = 0;
      pll_locked = 1'b1;
      while (sys_rst_n !== 1'b1) begin
         if (n > `COMPY_BOOT_HOLD + drop + 20) begin
            abort_run("system reset never released after PLL lock");
         end else begin
            @(negedge clk50);
            n++;
            pll_locked = !(n >= 10 && n < 10 + drop);
         end
      end
      assert (n == `COMPY_BOOT_HOLD + 1 + drop)
         else flag_mismatch($sformatf("boot hold took %0d cycles with a %0d cycle drop", n, drop));

      for (int g = 0; g < 40; g++) begin
         k = $urandom_range(0, `COMPY_KEY_COUNT - 1);
         keys.bits[k] = 1'b0;
         expect_quiet($urandom_range(1, GLITCH_MAX));
         keys.bits[k] = 1'b1;
         expect_quiet($urandom_range(`COMPY_TICK_DIV, 2 * `COMPY_TICK_DIV));
      end
      assert (key_mode_level == 1'b0 && buttons_level == '0 && sys_rst_n == 1'b1)
         else flag_mismatch("glitches changed a key level");

      for (int i = 0; i < `COMPY_KEY_COUNT; i++) begin
         move_key(i, 1'b1);
         repeat ($urandom_range(5, 20)) @(negedge clk50);
         move_key(i, 1'b0);
         repeat ($urandom_range(5, 20)) @(negedge clk50);
      end

      // user reset with the reset key held. A button still works meanwhile.
      move_key(`COMPY_KEY_COUNT - 1, 1'b1);
      assert (sys_rst_n == 1'b1) else flag_mismatch("sys_rst_n fell too early");
      @(negedge clk50);
      assert (sys_rst_n == 1'b0) else flag_mismatch("reset key did not assert sys_rst_n");
      move_key(2, 1'b1);
      move_key(2, 1'b0);
      move_key(`COMPY_KEY_COUNT - 1, 1'b0);
      assert (sys_rst_n == 1'b0) else flag_mismatch("sys_rst_n rose too early");
      @(negedge clk50);
      assert (sys_rst_n == 1'b1) else flag_mismatch("sys_rst_n stayed low after key release");

      for (int i = 0; i < `COMPY_KEY_COUNT; i++) begin
         hold_left[i] = $urandom_range(1, 30);
      end
      repeat (4000) begin
         for (int i = 0; i < `COMPY_KEY_COUNT; i++) begin
            if (hold_left[i] == 0) begin
               keys.bits[i] = ~keys.bits[i];
               hold_left[i] = $urandom_range(1, 30);
            end else begin
               hold_left[i]--;
            end
         end
         @(negedge clk50);
      end
      keys.bits = '1;
      n         = 0;
      while (!(key_mode_level == 1'b0 && buttons_level == '0 && sys_rst_n == 1'b1)) begin
         if (n == SETTLE_TIMEOUT) begin
            abort_run("keys did not settle after the random phase");
         end else begin
            @(negedge clk50);
            n++;
         end
      end

      $display("Everything OK");
      $finish;
   end

endmodule
